// File: hw/msx_io_pkg.sv
//====================================================================
// MSX storage and display glue, shared definitions
// Widths, menu status bit positions and cassette player states
//====================================================================

package msx_io_pkg;

   // Bus and data widths
   typedef logic [27:0] ddr3_addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [11:0] hdmi_dim_t;
   typedef logic [9:0]  crop_t;
   typedef logic [11:0] aspect_t;
   typedef logic [63:0] status_t;
   typedef logic [15:0] ioctl_index_t;

   //=================================================================
   // Menu status word
   //=================================================================
   // Bits 2:1 aspect ratio and 5:3 scandoubler effect are sliced directly
   localparam int ST_RESET    = 0;
   localparam int ST_TAPE_REW = 9;
   localparam int ST_DETACH   = 10;
   localparam int ST_VCROP    = 40;

   // Low 6 bits of the download index for a CAS file
   localparam logic [5:0] CAS_INDEX = 6'd5;

   // Cassette player
   typedef enum logic [1:0] {
      cas_idle,
      cas_fetch,
      cas_stream
   } cas_state_t;

endpackage

// File: hw/ddr3_rd_if.sv
//====================================================================
// DDR3 byte read port
// Requester holds rd and addr until memory returns ready with dout
//====================================================================
`timescale 1ns/10ps

interface ddr3_rd_if;
   import msx_io_pkg::*;

   ddr3_addr_t addr;
   logic       rd;
   byte_t      dout;
   logic       ready;

   modport requester (
      output addr,
      output rd,
      input  dout,
      input  ready
   );

   modport memory (
      input  addr,
      input  rd,
      output dout,
      output ready
   );

endinterface

// File: hw/video_crop.sv
//====================================================================
// Video crop and aspect ratio
// Picks vertical crop from the HDMI mode, plus scanline and hq2x select
//====================================================================
`timescale 1ns/10ps

module video_crop (
   input  logic                  clk21m,
   input  logic                  rst,
   input  msx_io_pkg::status_t   status,
   input  msx_io_pkg::hdmi_dim_t hdmi_width,
   input  msx_io_pkg::hdmi_dim_t hdmi_height,
   input  logic                  forced_scandoubler,
   output msx_io_pkg::aspect_t   arx,
   output msx_io_pkg::aspect_t   ary,
   output msx_io_pkg::crop_t     crop_size,
   output logic [1:0]            vga_sl,
   output logic                  hq2x,
   output logic                  scandoubler
);
   import msx_io_pkg::*;

   logic        sd_on;
   logic        wide;
   crop_t       vcrop;
   logic [1:0]  ar;
   logic [1:0]  ar_m1;
   logic [12:0] height_x15;

   assign sd_on      = (status[5:3] != 3'd0) || forced_scandoubler;
   assign ar         = status[2:1];
   assign ar_m1      = ar - 2'd1;
   // Height times 1.5, one bit wider so it cannot wrap
   assign height_x15 = {1'b0, hdmi_height} + {2'b00, hdmi_height[11:1]};

   always_comb begin
      vcrop = '0;
      wide  = 1'b0;
      if (!sd_on) begin
         if ({1'b0, hdmi_width} >= height_x15) begin
            case (hdmi_height)
               12'd480, 12'd720, 12'd1200: vcrop = 10'd240;
               12'd600, 12'd800: begin
                  vcrop = 10'd200;
                  wide  = status[ST_VCROP];
               end
               12'd768:  vcrop = 10'd256;
               12'd1080: vcrop = 10'd216;
               default:  vcrop = '0;
            endcase
         end else if (hdmi_width >= 12'd1440) begin
            // 4:3 modes too narrow for the wide test
            if (hdmi_height == 12'd1440) vcrop = 10'd240;
            if (hdmi_height == 12'd1536) vcrop = 10'd256;
         end
      end
   end

   always_ff @(posedge clk21m) begin
      if (rst) begin
         crop_size   <= '0;
         arx         <= '0;
         ary         <= '0;
         vga_sl      <= 2'd0;
         hq2x        <= 1'b0;
         scandoubler <= 1'b0;
      end else begin
         crop_size <= status[ST_VCROP] ? vcrop : crop_t'(0);
         if (ar == 2'd0) begin
            arx <= wide ? 12'd340 : 12'd400;
            ary <= 12'd300;
         end else begin
            arx <= {10'd0, ar_m1};
            ary <= '0;
         end
         vga_sl      <= (status[5:3] > 3'd2) ? status[4:3] - 2'd2 : 2'd0;
         hq2x        <= ~status[5] & (status[4] ^ status[3]);
         scandoubler <= sd_on;
      end
   end

endmodule

// File: hw/sd_activity.sv
//====================================================================
// SD card select and activity light
// Switches between real and virtual card, holds the disk LED on
//====================================================================
`timescale 1ns/10ps

module sd_activity #(
   parameter logic [31:0] SD_ACT_HOLD = 32'd1_000_000
) (
   input  logic       clk21m,
   input  logic       rst,
   input  logic       img_mounted_sd,
   input  logic       img_size_nonzero,
   input  logic       sd_mosi,
   input  logic       sd_miso_real,
   input  logic       sd_miso_virtual,
   input  logic       sd_clk_int,
   output logic       sd_cs,
   output logic       sd_sck,
   output logic       sd_mosi_pin,
   output logic       led_user,
   output logic [1:0] led_disk
);

   logic        vsd_sel;
   logic        miso_sel;
   logic        mosi_q;
   logic        miso_q;
   logic        line_edge;
   logic [31:0] act_cnt;
   logic        sd_act;

   // Virtual card owns the bus, real card pins are parked low
   assign miso_sel    = vsd_sel ? sd_miso_virtual : sd_miso_real;
   assign sd_cs       = vsd_sel;
   assign sd_sck      = sd_clk_int & ~vsd_sel;
   assign sd_mosi_pin = sd_mosi & ~vsd_sel;

   assign line_edge = (sd_mosi != mosi_q) || (miso_sel != miso_q);
   assign sd_act    = act_cnt < SD_ACT_HOLD;

   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, sd_act & ~vsd_sel};

   always_ff @(posedge clk21m) begin
      if (rst) begin
         vsd_sel <= 1'b0;
         mosi_q  <= 1'b0;
         miso_q  <= 1'b0;
         act_cnt <= SD_ACT_HOLD;
      end else begin
         if (img_mounted_sd) vsd_sel <= img_size_nonzero;
         mosi_q <= sd_mosi;
         miso_q <= miso_sel;
         // Any edge restarts the hold, then count up to it and stop
         if (line_edge) begin
            act_cnt <= '0;
         end else if (sd_act) begin
            act_cnt <= act_cnt + 32'd1;
         end
      end
   end

   // Real card clock stays low from the cycle the virtual card is picked
   sck_parked: assert property (@(posedge clk21m) disable iff (rst)
      (img_mounted_sd ? img_size_nonzero : vsd_sel) |=> !sd_sck);

endmodule

// File: hw/ddr3_arbiter.sv
//====================================================================
// DDR3 read port arbiter
// Download path wins a free port, grant holds until the read ends
//====================================================================
`timescale 1ns/10ps

module ddr3_arbiter (
   input  logic                   clk21m,
   input  logic                   rst,
   input  logic                   dl_req,
   input  msx_io_pkg::ddr3_addr_t dl_addr,
   input  logic                   dl_rd,
   input  msx_io_pkg::byte_t      ddr3_dout,
   input  logic                   ddr3_ready,
   ddr3_rd_if.memory              cas,
   output msx_io_pkg::ddr3_addr_t ddr3_addr,
   output logic                   ddr3_rd,
   output msx_io_pkg::byte_t      dl_dout,
   output logic                   dl_ready
);

   logic locked;
   logic grant_dl;
   logic sel_dl;

   // Owner of the port in this cycle
   assign sel_dl = locked ? grant_dl : dl_req;

   assign ddr3_addr = sel_dl ? dl_addr : cas.addr;
   assign ddr3_rd   = sel_dl ? dl_rd : cas.rd;

   assign dl_dout   = ddr3_dout;
   assign dl_ready  = sel_dl & ddr3_ready;
   assign cas.dout  = ddr3_dout;
   assign cas.ready = ~sel_dl & ddr3_ready;

   always_ff @(posedge clk21m) begin
      if (rst) begin
         locked   <= 1'b0;
         grant_dl <= 1'b0;
      end else if (!locked) begin
         if (ddr3_rd && !ddr3_ready) begin
            locked   <= 1'b1;
            grant_dl <= sel_dl;
         end
      end else if (ddr3_ready) begin
         locked <= 1'b0;
      end
   end

   // Read data only ever returns to the side that asked for it
   dl_ready_pending: assert property (@(posedge clk21m) disable iff (rst)
      dl_ready |-> dl_rd);
   cas_ready_pending: assert property (@(posedge clk21m) disable iff (rst)
      cas.ready |-> cas.rd);

endmodule

// File: hw/cas_player.sv
//====================================================================
// Cassette player
// Streams the loaded CAS image from DDR3 as bits, MSB first
//====================================================================
`timescale 1ns/10ps

module cas_player (
   input  logic                     clk21m,
   input  logic                     rst,
   input  msx_io_pkg::status_t      status,
   input  logic                     dl_active,
   input  msx_io_pkg::ioctl_index_t dl_index,
   input  logic                     motor,
   input  logic                     ce_tape,
   ddr3_rd_if.requester             mem,
   output logic                     cas_out
);
   import msx_io_pkg::*;

   cas_state_t state;
   ddr3_addr_t addr;
   logic       rd;
   logic       flush;
   byte_t      pf_byte;
   logic       pf_valid;
   byte_t      shifter;
   logic       sh_valid;
   logic [2:0] bit_cnt;
   logic       cas_dl;
   logic       cas_dl_q;
   logic       cas_load;
   logic       play;
   logic       rewind;
   logic       pf_load;
   logic       sh_load;
   logic       sh_step;

   assign cas_dl = dl_active && (dl_index[5:0] == CAS_INDEX);
   assign play   = cas_load & ~motor;
   // Menu reset and detach rewind the tape as well
   assign rewind = status[ST_TAPE_REW] | cas_dl | status[ST_RESET] | status[ST_DETACH];

   assign mem.addr = addr;
   assign mem.rd   = rd;

   assign pf_load = rd && mem.ready && !flush;
   assign sh_load = (state == cas_stream) && !sh_valid && pf_valid;
   assign sh_step = (state == cas_stream) && sh_valid && play && ce_tape;

   // Tape counts as loaded once a CAS download finishes
   always_ff @(posedge clk21m) begin
      if (rst) begin
         cas_dl_q <= 1'b0;
         cas_load <= 1'b0;
      end else begin
         cas_dl_q <= cas_dl;
         if (cas_dl_q && !cas_dl) cas_load <= 1'b1;
      end
   end

   //=================================================================
   // Byte fetch, prefetch and shift control
   //=================================================================
   always_ff @(posedge clk21m) begin
      if (rst) begin
         state    <= cas_idle;
         addr     <= '0;
         rd       <= 1'b0;
         flush    <= 1'b0;
         pf_valid <= 1'b0;
         sh_valid <= 1'b0;
         bit_cnt  <= '0;
         cas_out  <= 1'b0;
      end else begin
         if (rd && mem.ready) begin
            rd    <= 1'b0;
            flush <= 1'b0;
            if (flush) begin
               addr <= '0;
            end else begin
               pf_valid <= 1'b1;
               addr     <= addr + 28'd1;
            end
         end

         case (state)
            cas_idle: begin
               if (play && !rd) begin
                  rd    <= 1'b1;
                  state <= cas_fetch;
               end
            end
            cas_fetch: begin
               if (mem.ready) state <= cas_stream;
            end
            cas_stream: begin
               if (sh_load) begin
                  sh_valid <= 1'b1;
                  bit_cnt  <= '0;
                  pf_valid <= 1'b0;
               end
               if (sh_step) begin
                  cas_out <= shifter[7];
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) sh_valid <= 1'b0;
               end
               // Refill the prefetch slot while the shifter runs
               if (play && !rd && !pf_valid) rd <= 1'b1;
            end
            default: state <= cas_idle;
         endcase

         if (rewind) begin
            state    <= cas_idle;
            pf_valid <= 1'b0;
            sh_valid <= 1'b0;
            bit_cnt  <= '0;
            // A read in flight finishes first, its byte is dropped
            if (rd && !mem.ready) begin
               flush <= 1'b1;
            end else begin
               addr <= '0;
               rd   <= 1'b0;
            end
         end
      end
   end

   // Data path
   always_ff @(posedge clk21m) begin
      if (pf_load) pf_byte <= mem.dout;
      if (sh_load) begin
         shifter <= pf_byte;
      end else if (sh_step) begin
         shifter <= {shifter[6:0], 1'b0};
      end
   end

   // Read request stays up with a fixed address until the memory answers
   rd_held: assert property (@(posedge clk21m) disable iff (rst)
      mem.rd && !mem.ready |=> mem.rd && $stable(mem.addr));

endmodule

// File: hw/msx_io_top.sv
//====================================================================
// MSX storage and display glue, top level
// Video crop, SD activity, DDR3 sharing and cassette playback
//====================================================================
`timescale 1ns/10ps

module msx_io_top #(
   parameter logic [31:0] SD_ACT_HOLD = 32'd1_000_000
) (
   input  logic                     clk21m,
   input  logic                     rst,
   input  msx_io_pkg::status_t      status,
   input  msx_io_pkg::hdmi_dim_t    hdmi_width,
   input  msx_io_pkg::hdmi_dim_t    hdmi_height,
   input  logic                     forced_scandoubler,
   input  logic                     img_mounted_sd,
   input  logic                     img_size_nonzero,
   input  logic                     sd_mosi,
   input  logic                     sd_miso_real,
   input  logic                     sd_miso_virtual,
   input  logic                     sd_clk_int,
   input  logic                     dl_active,
   input  msx_io_pkg::ioctl_index_t dl_index,
   input  logic                     dl_req,
   input  msx_io_pkg::ddr3_addr_t   dl_addr,
   input  logic                     dl_rd,
   input  msx_io_pkg::byte_t        ddr3_dout,
   input  logic                     ddr3_ready,
   input  logic                     motor,
   input  logic                     ce_tape,
   output msx_io_pkg::aspect_t      arx,
   output msx_io_pkg::aspect_t      ary,
   output msx_io_pkg::crop_t        crop_size,
   output logic [1:0]               vga_sl,
   output logic                     hq2x,
   output logic                     scandoubler,
   output logic                     sd_cs,
   output logic                     sd_sck,
   output logic                     sd_mosi_pin,
   output logic                     led_user,
   output logic [1:0]               led_disk,
   output msx_io_pkg::ddr3_addr_t   ddr3_addr,
   output logic                     ddr3_rd,
   output msx_io_pkg::byte_t        dl_dout,
   output logic                     dl_ready,
   output logic                     cas_out
);

   // Cassette side of the shared DDR3 read port
   ddr3_rd_if cas_port ();

   video_crop video_crop_i (
      .clk21m             (clk21m),
      .rst                (rst),
      .status             (status),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .forced_scandoubler (forced_scandoubler),
      .arx                (arx),
      .ary                (ary),
      .crop_size          (crop_size),
      .vga_sl             (vga_sl),
      .hq2x               (hq2x),
      .scandoubler        (scandoubler)
   );

   sd_activity #(
      .SD_ACT_HOLD (SD_ACT_HOLD)
   ) sd_activity_i (
      .clk21m           (clk21m),
      .rst              (rst),
      .img_mounted_sd   (img_mounted_sd),
      .img_size_nonzero (img_size_nonzero),
      .sd_mosi          (sd_mosi),
      .sd_miso_real     (sd_miso_real),
      .sd_miso_virtual  (sd_miso_virtual),
      .sd_clk_int       (sd_clk_int),
      .sd_cs            (sd_cs),
      .sd_sck           (sd_sck),
      .sd_mosi_pin      (sd_mosi_pin),
      .led_user         (led_user),
      .led_disk         (led_disk)
   );

   ddr3_arbiter ddr3_arbiter_i (
      .clk21m     (clk21m),
      .rst        (rst),
      .dl_req     (dl_req),
      .dl_addr    (dl_addr),
      .dl_rd      (dl_rd),
      .ddr3_dout  (ddr3_dout),
      .ddr3_ready (ddr3_ready),
      .cas        (cas_port.memory),
      .ddr3_addr  (ddr3_addr),
      .ddr3_rd    (ddr3_rd),
      .dl_dout    (dl_dout),
      .dl_ready   (dl_ready)
   );

   cas_player cas_player_i (
      .clk21m    (clk21m),
      .rst       (rst),
      .status    (status),
      .dl_active (dl_active),
      .dl_index  (dl_index),
      .motor     (motor),
      .ce_tape   (ce_tape),
      .mem       (cas_port.requester),
      .cas_out   (cas_out)
   );

endmodule

// File: testbench/tb_msx_io.sv
//======================================================================
// Testbench for the MSX storage and display glue
// DDR3 read model, tape clock, video, SD and cassette checks
//======================================================================
`timescale 1ns/10ps

module tb_msx_io;
   import msx_io_pkg::*;

   logic         clk21m;
   logic         rst;
   status_t      status;
   hdmi_dim_t    hdmi_width;
   hdmi_dim_t    hdmi_height;
   logic         forced_scandoubler;
   logic         img_mounted_sd;
   logic         img_size_nonzero;
   logic         sd_mosi;
   logic         sd_miso_real;
   logic         sd_miso_virtual;
   logic         sd_clk_int;
   logic         dl_active;
   ioctl_index_t dl_index;
   logic         dl_req;
   ddr3_addr_t   dl_addr;
   logic         dl_rd;
   byte_t        ddr3_dout = 8'h00;
   logic         ddr3_ready = 1'b0;
   logic         motor;
   logic         ce_tape = 1'b0;
   aspect_t      arx;
   aspect_t      ary;
   crop_t        crop_size;
   logic [1:0]   vga_sl;
   logic         hq2x;
   logic         scandoubler;
   logic         sd_cs;
   logic         sd_sck;
   logic         sd_mosi_pin;
   logic         led_user;
   logic [1:0]   led_disk;
   ddr3_addr_t   ddr3_addr;
   logic         ddr3_rd;
   byte_t        dl_dout;
   logic         dl_ready;
   logic         cas_out;

   // Memory model and tape bookkeeping
   logic [31:0]  rng_state = 32'hff60;
   logic         mem_busy = 1'b0;
   int           mem_lat = 0;
   ddr3_addr_t   mem_addr = '0;
   logic         tape_run = 1'b0;
   logic [5:0]   tape_div = '0;
   logic         tape_seen = 1'b0;
   logic         tape_check = 1'b0;
   logic         vsd_on = 1'b0;
   int           bit_idx = 0;

   msx_io_top #(
      .SD_ACT_HOLD (32'd200)
   ) msx_io_top_i (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Memory contents are the low address byte XOR 5A
   function automatic byte_t model_byte(input ddr3_addr_t a);
      return a[7:0] ^ 8'h5A;
   endfunction

   // Tape bit number idx, MSB of each byte first
   function automatic logic expected_tape_bit(input int idx);
      byte_t b;
      b = model_byte(ddr3_addr_t'(idx / 8));
      return b[7 - (idx % 8)];
   endfunction

   // Scanline level for each scandoubler effect setting
   function automatic logic [1:0] expected_vga_sl(input logic [2:0] fx);
      case (fx)
         3'd3, 3'd7: return 2'd1;
         3'd4:       return 2'd2;
         3'd5:       return 2'd3;
         default:    return 2'd0;
      endcase
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got == exp)
      else stop_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
   endtask

   task automatic set_video(input status_t st, input hdmi_dim_t w, input hdmi_dim_t h);
      @(posedge clk21m);
      status      <= st;
      hdmi_width  <= w;
      hdmi_height <= h;
      // Registered outputs, look two edges later
      repeat (2) @(posedge clk21m);
      @(negedge clk21m);
   endtask

   task automatic dl_read(input ddr3_addr_t a);
      int waited;
      waited = 0;
      @(posedge clk21m);
      dl_req  <= 1'b1;
      dl_addr <= a;
      dl_rd   <= 1'b1;
      do begin
         @(negedge clk21m);
         waited++;
      end while (!dl_ready && waited < 100);
      if (!dl_ready) stop_run("download read got no dl_ready within 100 cycles");
      check_value("dl_dout", 32'(dl_dout), 32'(model_byte(a)));
      @(posedge clk21m);
      dl_req <= 1'b0;
      dl_rd  <= 1'b0;
   endtask

   task automatic wait_tape_bits(input int n);
      int waited;
      waited = 0;
      while (bit_idx < n && waited < (n + 4) * 64) begin
         @(posedge clk21m);
         waited++;
      end
      if (bit_idx < n) stop_run($sformatf("only %0d tape bits arrived, wanted %0d", bit_idx, n));
   endtask

   initial begin
      clk21m = 1'b0;
      forever #4 clk21m = ~clk21m;
   end

   // Tape clock enable, one pulse every 64 cycles
   always @(posedge clk21m) begin
      tape_seen <= ce_tape;
      if (!tape_run) begin
         tape_div <= '0;
         ce_tape  <= 1'b0;
      end else begin
         tape_div <= tape_div + 6'd1;
         ce_tape  <= (tape_div == 6'd63);
      end
   end

   //===================================================================
   // DDR3 model, 1 to 20 cycles per read
   //===================================================================
   always @(posedge clk21m) begin
      if (rst) begin
         ddr3_ready <= 1'b0;
         mem_busy = 1'b0;
      end else if (ddr3_ready) begin
         ddr3_ready <= 1'b0;
      end else if (mem_busy) begin
         mem_lat = mem_lat - 1;
         if (mem_lat == 0) begin
            ddr3_dout  <= model_byte(mem_addr);
            ddr3_ready <= 1'b1;
            mem_busy = 1'b0;
         end
      end else if (ddr3_rd) begin
         rng_state = xorshift(rng_state);
         mem_lat   = 1 + int'(rng_state % 32'd20);
         mem_addr  = ddr3_addr;
         mem_busy  = 1'b1;
      end
   end

   // Every consumed tape pulse shows the next bit
   always @(negedge clk21m) begin
      if (tape_check && tape_seen) begin
         check_value("cas_out", 32'(cas_out), 32'(expected_tape_bit(bit_idx)));
         bit_idx = bit_idx + 1;
      end
   end

   sck_parked: assert property (@(posedge clk21m) disable iff (rst) vsd_on |-> !sd_sck)
      else stop_run("sd_sck went high while the virtual card was selected");
   tape_quiet: assert property (@(posedge clk21m) disable iff (rst)
      !$past(ce_tape) |-> $stable(cas_out))
      else stop_run("cas_out changed without a tape pulse");

   initial begin
      status_t    st;
      logic [2:0] sel;
      int         n;
      rst                = 1'b1;
      status             = '0;
      hdmi_width         = '0;
      hdmi_height        = '0;
      forced_scandoubler = 1'b0;
      img_mounted_sd     = 1'b0;
      img_size_nonzero   = 1'b0;
      sd_mosi            = 1'b0;
      sd_miso_real       = 1'b0;
      sd_miso_virtual    = 1'b0;
      sd_clk_int         = 1'b0;
      dl_active          = 1'b0;
      dl_index           = '0;
      dl_req             = 1'b0;
      dl_addr            = '0;
      dl_rd              = 1'b0;
      motor              = 1'b0;
      repeat (10) @(posedge clk21m);
      rst <= 1'b0;

      //================================================================
      // Crop, aspect, scanlines and hq2x
      //================================================================
      st = '0;
      st[ST_VCROP] = 1'b1;
      set_video(st, 12'd1920, 12'd1080);
      check_value("crop_size", 32'(crop_size), 32'd216);
      check_value("arx", 32'(arx), 32'd400);
      check_value("ary", 32'(ary), 32'd300);
      set_video(st, 12'd1024, 12'd600);
      check_value("crop_size", 32'(crop_size), 32'd200);
      check_value("arx", 32'(arx), 32'd340);
      st[2:1] = 2'd2;
      set_video(st, 12'd1024, 12'd600);
      check_value("arx", 32'(arx), 32'd1);
      check_value("ary", 32'(ary), 32'd0);
      st[2:1] = 2'd0;
      for (n = 0; n < 8; n++) begin
         sel = 3'(n);
         st[5:3] = sel;
         set_video(st, 12'd1920, 12'd1080);
         check_value("crop_size", 32'(crop_size), (sel == 3'd0) ? 32'd216 : 32'd0);
         check_value("scandoubler", 32'(scandoubler), 32'(sel != 3'd0));
         check_value("vga_sl", 32'(vga_sl), 32'(expected_vga_sl(sel)));
         check_value("hq2x", 32'(hq2x), 32'((sel == 3'd1) || (sel == 3'd2)));
      end

      // SD card, real card activity first
      @(posedge clk21m);
      sd_miso_real <= 1'b1;
      @(posedge clk21m);
      sd_miso_real <= 1'b0;
      @(posedge clk21m);
      @(negedge clk21m);
      check_value("led_disk", 32'(led_disk), 32'd3);
      check_value("led_user", 32'(led_user), 32'd0);
      n = 0;
      while (led_disk[0] && n < 400) begin
         @(posedge clk21m);
         n++;
         @(negedge clk21m);
      end
      if (led_disk[0]) stop_run("disk light stayed on after the miso activity");

      // Virtual image mounted
      @(posedge clk21m);
      img_size_nonzero <= 1'b1;
      img_mounted_sd   <= 1'b1;
      @(posedge clk21m);
      img_mounted_sd   <= 1'b0;
      repeat (2) @(posedge clk21m);
      @(negedge clk21m);
      check_value("sd_cs", 32'(sd_cs), 32'd1);
      vsd_on = 1'b1;
      for (n = 0; n < 16; n++) begin
         @(posedge clk21m);
         sd_clk_int <= ~sd_clk_int;
      end
      @(posedge clk21m);
      sd_mosi <= 1'b1;
      n = 0;
      do begin
         @(posedge clk21m);
         n++;
         @(negedge clk21m);
      end while (!led_user && n < 2);
      assert (led_user) else stop_run("led_user did not rise within 2 cycles of a mosi edge");
      check_value("led_disk", 32'(led_disk), 32'd2);
      check_value("sd_mosi_pin", 32'(sd_mosi_pin), 32'd0);
      while (led_user && n < 400) begin
         @(posedge clk21m);
         n++;
         @(negedge clk21m);
      end
      assert (n >= 200 && n <= 202)
      else stop_run($sformatf("led_user fell %0d cycles after the mosi edge", n));

      //================================================================
      // Cassette stream, shared port and rewind
      //================================================================
      @(posedge clk21m);
      dl_index  <= {10'h001, CAS_INDEX};
      dl_active <= 1'b1;
      repeat (8) @(posedge clk21m);
      dl_active <= 1'b0;
      @(posedge clk21m);
      tape_run   <= 1'b1;
      tape_check = 1'b1;
      wait_tape_bits(12);
      // Back to back download reads across the next cassette refill
      n = 0;
      while (bit_idx < 20 && n < 300) begin
         dl_read(28'h0000100 + ddr3_addr_t'(n * 29));
         n++;
      end
      wait_tape_bits(48);

      n = 0;
      do begin
         @(negedge clk21m);
         n++;
      end while (!tape_seen && n < 200);
      if (!tape_seen) stop_run("no tape pulse arrived before the rewind");
      @(posedge clk21m);
      status[ST_TAPE_REW] <= 1'b1;
      bit_idx = 0;
      @(posedge clk21m);
      status[ST_TAPE_REW] <= 1'b0;
      wait_tape_bits(24);

      $display("all tests passed");
      $finish;
   end

endmodule

// File: flist.f
hw/msx_io_pkg.sv
hw/ddr3_rd_if.sv
hw/video_crop.sv
hw/sd_activity.sv
hw/ddr3_arbiter.sv
hw/cas_player.sv
hw/msx_io_top.sv
testbench/tb_msx_io.sv

// File: Makefile
TOP = tb_msx_io

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
